/* source/chess_pkg.sv */
package chess_pkg;

   // Board geometry, only 8x8 is supported
   localparam int BOARD_ROWS = 8;
   localparam int BOARD_COLS = 8;

   // Piece kind codes
   localparam logic [2:0] PIECE_EMPTY  = 3'd0;
   localparam logic [2:0] PIECE_PAWN   = 3'd1;
   localparam logic [2:0] PIECE_KNIGHT = 3'd2;
   localparam logic [2:0] PIECE_BISHOP = 3'd3;
   localparam logic [2:0] PIECE_ROOK   = 3'd4;
   localparam logic [2:0] PIECE_QUEEN  = 3'd5;
   localparam logic [2:0] PIECE_KING   = 3'd6;
   // Kind 7 is unused and reads as empty

   typedef enum logic {
      SIDE_WHITE = 1'b0,
      SIDE_BLACK = 1'b1
   } side_t;

   typedef struct packed {
      logic       color; // 0 white, 1 black
      logic [2:0] kind;
   } piece_t;

   // Square index is row * 8 + col
   // Row 0 is rank 1 and white pawns move up
   typedef piece_t [63:0] board_t;

   typedef logic [5:0] sq_idx_t;

   typedef logic [63:0] attack_map_t; // One bit per square

   typedef struct packed {
      logic       white_in_check;
      logic       black_in_check;
      logic [6:0] white_count;     // Squares white attacks
      logic [6:0] black_count;     // Squares black attacks
   } check_summary_t;

endpackage

/* source/board_store.sv */
`timescale 1ns/1ns

module board_store (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               wr,
   input  chess_pkg::sq_idx_t wr_sq,
   input  chess_pkg::piece_t  wr_piece,
   input  logic               start,
   output chess_pkg::board_t  board,
   output logic               board_valid
);

   import chess_pkg::*;

   logic       launch_q;  // Start taken and waiting for launch
   logic [1:0] busy_cnt;  // Evaluation cycles left
   logic       busy;
   logic       accept;

   assign busy = busy_cnt != 2'd0;

   // A start one cycle after an accepted one is also dropped
   assign accept = start && !busy && !launch_q;

   // Square register file
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < BOARD_ROWS * BOARD_COLS; i++)
         begin
            board[i] <= '{color: SIDE_WHITE, kind: PIECE_EMPTY}; // All squares empty
         end
      end
      else
      begin
         // Write index decode
         for (int i = 0; i < BOARD_ROWS * BOARD_COLS; i++)
         begin
            if (wr && wr_sq == sq_idx_t'(i))
               board[i] <= wr_piece;
         end
      end
   end

   // Start and busy sequencing
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         launch_q    <= 1'b0;
         board_valid <= 1'b0;
         busy_cnt    <= 2'd0;
      end
      else
      begin
         launch_q    <= accept;
         board_valid <= launch_q;  // One cycle pulse
         if (launch_q)
            busy_cnt <= 2'd3;      // Covers evaluate, check and done
         else if (busy)
            busy_cnt <= busy_cnt - 2'd1;
      end
   end

endmodule

/* source/square_attack.sv */
`timescale 1ns/1ns

module square_attack #(
   parameter int               ROW      = 0,
   parameter int               COL      = 0,
   parameter chess_pkg::side_t ATTACKER = chess_pkg::SIDE_WHITE
)
(
   input  logic              clk,
   input  logic              rst_n,
   input  chess_pkg::board_t board,
   input  logic              board_valid,
   output logic              attacking,
   output logic              attacking_valid
);

   import chess_pkg::*;

   // Row step from this square back to an attacking pawn
   localparam int PAWN_DR = (ATTACKER == SIDE_WHITE) ? -1 : 1;

   // Knight jumps
   localparam int KNIGHT_DR [8] = '{ 2,  2, -2, -2,  1,  1, -1, -1};
   localparam int KNIGHT_DC [8] = '{ 1, -1,  1, -1,  2, -2,  2, -2};

   // Orthogonal directions first, then diagonal
   // King steps reuse these eight
   localparam int RAY_DR [8] = '{ 1, -1,  0,  0,  1,  1, -1, -1};
   localparam int RAY_DC [8] = '{ 0,  0,  1, -1,  1, -1,  1, -1};

   logic hit;  // Any attacker found

   function automatic logic on_board(int r, int c);
      return r >= 0 && r < BOARD_ROWS && c >= 0 && c < BOARD_COLS;
   endfunction

   function automatic piece_t piece_at(board_t b, int r, int c);
      return b[sq_idx_t'(r * BOARD_COLS + c)];
   endfunction

   // Attacker's piece of one kind at (r, c), off-board gives 0
   function automatic logic has_piece(board_t b, int r, int c, logic [2:0] kind);
      piece_t p;
      if (!on_board(r, c))
         return 1'b0;
      p = piece_at(b, r, c);
      return (p.color == ATTACKER) && (p.kind == kind);
   endfunction

   function automatic logic is_occupied(piece_t p);
      return p.kind != PIECE_EMPTY && p.kind <= PIECE_KING;  // Code 7 is empty
   endfunction

   always_comb
   begin
      int     r;
      int     c;
      logic   blocked;
      piece_t p;
      r       = 0;
      c       = 0;
      blocked = 1'b0;
      p       = '0;
      hit     = 1'b0;

      // Pawn diagonals
      if (has_piece(board, ROW + PAWN_DR, COL - 1, PIECE_PAWN) ||
          has_piece(board, ROW + PAWN_DR, COL + 1, PIECE_PAWN))
         hit = 1'b1;

      // Fixed offsets
      for (int i = 0; i < 8; i++)
      begin
         if (has_piece(board, ROW + KNIGHT_DR[i], COL + KNIGHT_DC[i], PIECE_KNIGHT))
            hit = 1'b1;
         if (has_piece(board, ROW + RAY_DR[i], COL + RAY_DC[i], PIECE_KING))
            hit = 1'b1;
      end

      // Sliding rays
      for (int d = 0; d < 8; d++)
      begin
         blocked = 1'b0;  // Fresh ray
         for (int s = 1; s < 8; s++)
         begin
            r = ROW + s * RAY_DR[d];
            c = COL + s * RAY_DC[d];
            if (!blocked && on_board(r, c))
            begin
               p = piece_at(board, r, c);
               if (is_occupied(p))
               begin
                  blocked = 1'b1;  // Nothing past the first piece
                  // Queen on any ray, rook orthogonal, bishop diagonal
                  if (p.color == ATTACKER &&
                      (p.kind == PIECE_QUEEN ||
                       p.kind == ((d < 4) ? PIECE_ROOK : PIECE_BISHOP)))
                     hit = 1'b1;
               end
            end
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         attacking       <= 1'b0;
         attacking_valid <= 1'b0;
      end
      else
      begin
         attacking_valid <= board_valid;
         if (board_valid)
            attacking <= hit;  // Held until next evaluation
      end
   end

endmodule

/* source/board_attack.sv */
`timescale 1ns/1ns

module board_attack (
   input  logic                   clk,
   input  logic                   rst_n,
   input  chess_pkg::board_t      board,
   input  logic                   board_valid,
   output chess_pkg::attack_map_t white_attacks,
   output chess_pkg::attack_map_t black_attacks,
   output logic                   maps_valid
);

   import chess_pkg::*;

   attack_map_t white_valid;  // Per square valid pulses
   attack_map_t black_valid;

   // All 128 evaluators pulse together
   assign maps_valid = (&white_valid) & (&black_valid);

   generate
      for (genvar row = 0; row < BOARD_ROWS; row++)
      begin : g_row
         for (genvar col = 0; col < BOARD_COLS; col++)
         begin : g_col

            // White attacks on this square
            square_attack #(
               .ROW      (row),
               .COL      (col),
               .ATTACKER (SIDE_WHITE)
            )
            i_white (
               .clk             (clk),
               .rst_n           (rst_n),
               .board           (board),
               .board_valid     (board_valid),
               .attacking       (white_attacks[row * BOARD_COLS + col]),
               .attacking_valid (white_valid[row * BOARD_COLS + col])
            );

            // Black attacks on this square
            square_attack #(
               .ROW      (row),
               .COL      (col),
               .ATTACKER (SIDE_BLACK)
            )
            i_black (
               .clk             (clk),
               .rst_n           (rst_n),
               .board           (board),
               .board_valid     (board_valid),
               .attacking       (black_attacks[row * BOARD_COLS + col]),
               .attacking_valid (black_valid[row * BOARD_COLS + col])
            );

         end
      end
   endgenerate

endmodule

/* source/king_check.sv */
`timescale 1ns/1ns

module king_check (
   input  logic                      clk,
   input  logic                      rst_n,
   input  chess_pkg::board_t         board,
   input  chess_pkg::attack_map_t    white_attacks,
   input  chess_pkg::attack_map_t    black_attacks,
   input  logic                      maps_valid,
   output chess_pkg::check_summary_t summary,
   output logic                      done
);

   import chess_pkg::*;

   check_summary_t summary_next;

   // Squares holding a king of one side
   function automatic attack_map_t king_mask(board_t b, side_t side);
      attack_map_t m;
      m = '0;
      for (int i = 0; i < BOARD_ROWS * BOARD_COLS; i++)
         m[i] = (b[i].kind == PIECE_KING) && (side_t'(b[i].color) == side);
      return m;
   endfunction

   // Population count, 0 to 64
   function automatic logic [6:0] count_bits(attack_map_t m);
      logic [6:0] n;
      n = '0;
      for (int i = 0; i < BOARD_ROWS * BOARD_COLS; i++)
         n = n + 7'(m[i]);
      return n;
   endfunction

   always_comb
   begin
      // No king means no check
      summary_next.white_in_check = |(king_mask(board, SIDE_WHITE) & black_attacks);
      summary_next.black_in_check = |(king_mask(board, SIDE_BLACK) & white_attacks);
      summary_next.white_count    = count_bits(white_attacks);
      summary_next.black_count    = count_bits(black_attacks);
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         summary <= '0;
         done    <= 1'b0;
      end
      else
      begin
         done <= maps_valid;  // Single pulse per evaluation
         if (maps_valid)
            summary <= summary_next;
      end
   end

endmodule

/* source/chess_attack_top.sv */
`timescale 1ns/1ns

module chess_attack_top (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      wr,
   input  chess_pkg::sq_idx_t        wr_sq,
   input  chess_pkg::piece_t         wr_piece,
   input  logic                      start,
   output chess_pkg::attack_map_t    white_attacks,
   output chess_pkg::attack_map_t    black_attacks,
   output chess_pkg::check_summary_t summary,
   output logic                      done
);

   import chess_pkg::*;

   board_t board;        // Live position
   logic   board_valid;  // Launch pulse
   logic   maps_valid;   // Both maps ready

   board_store i_store (
      .clk         (clk),
      .rst_n       (rst_n),
      .wr          (wr),
      .wr_sq       (wr_sq),
      .wr_piece    (wr_piece),
      .start       (start),
      .board       (board),
      .board_valid (board_valid)
   );

   board_attack i_attack (
      .clk           (clk),
      .rst_n         (rst_n),
      .board         (board),
      .board_valid   (board_valid),
      .white_attacks (white_attacks),
      .black_attacks (black_attacks),
      .maps_valid    (maps_valid)
   );

   king_check i_check (
      .clk           (clk),
      .rst_n         (rst_n),
      .board         (board),         // For king lookup
      .white_attacks (white_attacks),
      .black_attacks (black_attacks),
      .maps_valid    (maps_valid),
      .summary       (summary),
      .done          (done)
   );

endmodule

/* tb/chess_attack_sva.sv */
`timescale 1ns/1ns

module chess_attack_sva (
   input logic                   clk,
   input logic                   rst_n,
   input logic                   accept,        // Start taken by the store
   input logic                   busy,
   input logic                   board_valid,
   input logic                   maps_valid,
   input logic                   done,
   input chess_pkg::attack_map_t white_attacks,
   input chess_pkg::attack_map_t black_attacks
);

   logic seen_done;  // First evaluation finished

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         seen_done <= 1'b0;
      else if (done)
         seen_done <= 1'b1;
   end

   // Done set at the third edge after the start, so it is sampled at the fourth
   a_start_to_done: assert property (@(posedge clk) disable iff (!rst_n)
      $past(accept, 4) |-> done)
      else $error("done missing three cycles after an accepted start");

   a_done_from_start: assert property (@(posedge clk) disable iff (!rst_n)
      done |-> $past(accept, 4))
      else $error("done pulsed without an accepted start three cycles earlier");

   a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
      !(done && $past(done)))
      else $error("done high for two consecutive cycles");

   // Launch only from an idle store
   a_launch_idle: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(board_valid) |-> !$past(busy))
      else $error("board_valid rose while busy");

   // Maps clear before the first result lands
   a_maps_clear: assert property (@(posedge clk) disable iff (!rst_n)
      !(seen_done || maps_valid || done) |-> (white_attacks == '0 && black_attacks == '0))
      else $error("attack maps nonzero before the first done");

endmodule

bind chess_attack_top chess_attack_sva i_sva (
   .clk           (clk),
   .rst_n         (rst_n),
   .accept        (i_store.accept),
   .busy          (i_store.busy),
   .board_valid   (board_valid),
   .maps_valid    (maps_valid),
   .done          (done),
   .white_attacks (white_attacks),
   .black_attacks (black_attacks)
);

/* tb/tb_chess_attack.sv */
`timescale 1ns/1ns

module tb_chess_attack;

   import chess_pkg::*;

   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYCLES = 10;
   localparam int NUM_RANDOM   = 40;
   localparam int DONE_LIMIT   = 20;  // Cycles allowed from start to done
   // Reset, single pieces, blocking, check cases, random, double start
   localparam int NUM_TESTS    = 1 + 6 * 2 * 4 + 3 + 5 + NUM_RANDOM + 1;
   localparam int WATCHDOG_NS  = (NUM_TESTS * 100 + RESET_CYCLES) * CLK_PERIOD;

   localparam int STEP_R [8] = '{0, 0, 1, -1, 1, 1, -1, -1};  // Straight lines first
   localparam int STEP_C [8] = '{1, -1, 0, 0, 1, -1, 1, -1};
   localparam int JUMP_R [8] = '{1, 1, -1, -1, 2, 2, -2, -2};
   localparam int JUMP_C [8] = '{2, -2, 2, -2, 1, -1, 1, -1};
   localparam int SINGLE_SQ [4] = '{0, 31, 27, 60};           // a1, h4, d4, e8

   logic           clk = 1'b0;
   logic           rst_n;
   logic           wr;
   sq_idx_t        wr_sq;
   piece_t         wr_piece;
   logic           start;
   attack_map_t    white_attacks;
   attack_map_t    black_attacks;
   check_summary_t summary;
   logic           done;

   board_t         tb_board;             // Position for the next test
   attack_map_t    exp_white;
   attack_map_t    exp_black;
   check_summary_t exp_summary;
   int             mismatch_count = 0;   // Checker side
   int             done_count     = 0;
   int             tests_passed   = 0;
   int             tests_failed   = 0;
   int             test_idx       = 0;
   int unsigned    seed_init;

   chess_attack_top i_dut (
      .clk           (clk),
      .rst_n         (rst_n),
      .wr            (wr),
      .wr_sq         (wr_sq),
      .wr_piece      (wr_piece),
      .start         (start),
      .white_attacks (white_attacks),
      .black_attacks (black_attacks),
      .summary       (summary),
      .done          (done)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic inside_board(int r, int c);
      return r >= 0 && r < 8 && c >= 0 && c < 8;
   endfunction

   function automatic attack_map_t mark(attack_map_t m, int r, int c);
      attack_map_t res;
      res = m;
      if (inside_board(r, c))
         res[sq_idx_t'(r * 8 + c)] = 1'b1;  // Off-board targets dropped
      return res;
   endfunction

   // Reference model, spreads each piece's reach outward from its own square
   function automatic attack_map_t ref_attacks(board_t b, side_t side);
      attack_map_t m;
      piece_t      p;
      piece_t      q;
      int          r;
      int          c;
      int          tr;
      int          tc;
      logic        stop;
      m = '0;
      for (int sq = 0; sq < 64; sq++)
      begin
         p = b[sq_idx_t'(sq)];
         r = sq / 8;
         c = sq % 8;
         if (p.color == side)
         begin
            case (p.kind)
               PIECE_PAWN:
               begin
                  tr = (side == SIDE_WHITE) ? r + 1 : r - 1;  // Forward capture rank
                  m  = mark(m, tr, c - 1);
                  m  = mark(m, tr, c + 1);
               end
               PIECE_KNIGHT:
                  for (int i = 0; i < 8; i++)
                     m = mark(m, r + JUMP_R[i], c + JUMP_C[i]);
               PIECE_KING:
                  for (int i = 0; i < 8; i++)
                     m = mark(m, r + STEP_R[i], c + STEP_C[i]);
               PIECE_BISHOP, PIECE_ROOK, PIECE_QUEEN:
                  for (int d = 0; d < 8; d++)
                  begin
                     // Rook skips diagonals, bishop skips straight lines
                     if (!(p.kind == PIECE_ROOK && d >= 4) && !(p.kind == PIECE_BISHOP && d < 4))
                     begin
                        tr   = r + STEP_R[d];
                        tc   = c + STEP_C[d];
                        stop = 1'b0;
                        while (!stop && inside_board(tr, tc))
                        begin
                           m    = mark(m, tr, tc);  // Blocker square itself is hit
                           q    = b[sq_idx_t'(tr * 8 + tc)];
                           stop = q.kind != PIECE_EMPTY && q.kind != 3'd7;
                           tr   = tr + STEP_R[d];
                           tc   = tc + STEP_C[d];
                        end
                     end
                  end
               default: ;  // Empty or unused code
            endcase
         end
      end
      return m;
   endfunction

   function automatic check_summary_t ref_summary(board_t b, attack_map_t wm, attack_map_t bm);
      check_summary_t s;
      int             wn;
      int             bn;
      s  = '0;
      wn = 0;
      bn = 0;
      for (int sq = 0; sq < 64; sq++)
      begin
         if (wm[sq_idx_t'(sq)])
            wn++;
         if (bm[sq_idx_t'(sq)])
            bn++;
         if (b[sq_idx_t'(sq)].kind == PIECE_KING)
         begin
            if (b[sq_idx_t'(sq)].color == SIDE_WHITE && bm[sq_idx_t'(sq)])
               s.white_in_check = 1'b1;
            if (b[sq_idx_t'(sq)].color == SIDE_BLACK && wm[sq_idx_t'(sq)])
               s.black_in_check = 1'b1;
         end
      end
      s.white_count = 7'(wn);
      s.black_count = 7'(bn);
      return s;
   endfunction

   // Compare every result against the expected values
   always @(negedge clk)
   begin
      if (rst_n && done)
      begin
         done_count++;
         assert (white_attacks == exp_white)
         else
         begin
            $display("[ERROR] %0t white_attacks expected %h got %h",
                     $time, exp_white, white_attacks);
            mismatch_count++;
         end
         assert (black_attacks == exp_black)
         else
         begin
            $display("[ERROR] %0t black_attacks expected %h got %h",
                     $time, exp_black, black_attacks);
            mismatch_count++;
         end
         assert (summary == exp_summary)
         else
         begin
            $display("[ERROR] %0t summary expected %h got %h", $time, exp_summary, summary);
            mismatch_count++;
         end
      end
   end

   task automatic place(input int sq, input logic color, input logic [2:0] kind);
      tb_board[sq_idx_t'(sq)] = '{color: color, kind: kind};
   endtask

   task automatic finish_test(input string name, input logic ok);
      if (ok)
         tests_passed++;
      else
         tests_failed++;
      $display("Test %0d %s: %s", test_idx, name, ok ? "ok" : "FAILED");
   endtask

   // All 64 squares written, so old pieces never linger
   task automatic load_board();
      for (int i = 0; i < 64; i++)
      begin
         @(negedge clk);
         wr       = 1'b1;
         wr_sq    = sq_idx_t'(i);
         wr_piece = tb_board[sq_idx_t'(i)];
      end
      @(negedge clk);
      wr = 1'b0;
   endtask

   task automatic run_eval(input string name, input logic double_start);
      int   errs_before;
      int   dones_before;
      int   waited;
      logic ok;
      errs_before  = mismatch_count;
      dones_before = done_count;
      waited       = 0;
      ok           = 1'b1;
      test_idx++;
      exp_white    = ref_attacks(tb_board, SIDE_WHITE);
      exp_black    = ref_attacks(tb_board, SIDE_BLACK);
      exp_summary  = ref_summary(tb_board, exp_white, exp_black);
      load_board();
      start = 1'b1;
      @(negedge clk);
      start = double_start;  // Second pulse arrives while busy
      @(negedge clk);
      start = 1'b0;
      while (done_count == dones_before && waited < DONE_LIMIT)
      begin
         @(posedge clk);
         waited++;
      end
      if (done_count == dones_before)
      begin
         $display("Test %0d %s: no done pulse within %0d cycles", test_idx, name, DONE_LIMIT);
         ok = 1'b0;
      end
      if (double_start)
      begin
         repeat (10) @(posedge clk);
         assert (done_count - dones_before == 1)
         else
         begin
            $display("Test %0d %s: expected one done pulse but saw %0d",
                     test_idx, name, done_count - dones_before);
            ok = 1'b0;
         end
      end
      @(negedge clk);
      if (mismatch_count != errs_before)
         ok = 1'b0;
      finish_test(name, ok);
   endtask

   initial
   begin
      logic ok;
      int   density;
      seed_init = $urandom(32'h71a1);
      rst_n     = 1'b0;
      wr        = 1'b0;
      wr_sq     = '0;
      wr_piece  = '0;
      start     = 1'b0;
      tb_board  = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // Outputs idle after reset, no done without a start
      test_idx++;
      ok = 1'b1;
      assert (white_attacks == '0)
      else
      begin
         $display("[ERROR] %0t white_attacks expected 0 got %h", $time, white_attacks);
         ok = 1'b0;
      end
      assert (black_attacks == '0)
      else
      begin
         $display("[ERROR] %0t black_attacks expected 0 got %h", $time, black_attacks);
         ok = 1'b0;
      end
      assert (summary == '0)
      else
      begin
         $display("[ERROR] %0t summary expected 0 got %h", $time, summary);
         ok = 1'b0;
      end
      repeat (20) @(posedge clk);
      assert (done_count == 0)
      else
      begin
         $display("Test %0d: done pulsed although no start was given", test_idx);
         ok = 1'b0;
      end
      finish_test("reset state", ok);

      // Each kind and colour alone on corner, edge and centre squares
      for (int k = 1; k <= 6; k++)
         for (int col = 0; col < 2; col++)
            for (int s = 0; s < 4; s++)
            begin
               tb_board = '0;
               place(SINGLE_SQ[s], 1'(col), 3'(k));
               run_eval($sformatf("single kind %0d colour %0d square %0d",
                                  k, col, SINGLE_SQ[s]), 1'b0);
            end

      // Sliders stopped by pieces of both colours
      tb_board = '0;
      place(27, SIDE_WHITE, PIECE_ROOK);
      place(30, SIDE_WHITE, PIECE_PAWN);
      place(11, SIDE_BLACK, PIECE_KNIGHT);
      place(51, SIDE_BLACK, PIECE_BISHOP);
      run_eval("blocked rook", 1'b0);
      tb_board = '0;
      place(0, SIDE_BLACK, PIECE_QUEEN);
      place(18, SIDE_WHITE, PIECE_PAWN);
      place(3, SIDE_BLACK, PIECE_ROOK);
      place(32, SIDE_WHITE, PIECE_KNIGHT);
      run_eval("blocked queen", 1'b0);
      tb_board = '0;
      place(36, SIDE_WHITE, PIECE_BISHOP);
      place(54, SIDE_BLACK, PIECE_PAWN);
      place(18, SIDE_WHITE, PIECE_KING);
      place(50, SIDE_BLACK, PIECE_QUEEN);
      run_eval("blocked bishop", 1'b0);

      // King safety cases
      tb_board = '0;
      place(4, SIDE_WHITE, PIECE_KING);
      place(60, SIDE_BLACK, PIECE_ROOK);
      place(63, SIDE_BLACK, PIECE_KING);
      run_eval("white king checked by rook", 1'b0);
      place(12, SIDE_WHITE, PIECE_PAWN);  // Pawn shields e1
      run_eval("white king shielded", 1'b0);
      tb_board = '0;
      place(60, SIDE_BLACK, PIECE_KING);
      place(45, SIDE_WHITE, PIECE_KNIGHT);
      place(0, SIDE_WHITE, PIECE_KING);
      run_eval("black king checked by knight", 1'b0);
      tb_board = '0;
      place(36, SIDE_BLACK, PIECE_KING);
      place(27, SIDE_WHITE, PIECE_PAWN);
      place(7, SIDE_WHITE, PIECE_KING);
      place(15, SIDE_BLACK, PIECE_QUEEN);
      run_eval("both kings in check", 1'b0);
      tb_board = '0;
      place(20, SIDE_WHITE, PIECE_QUEEN);
      place(44, SIDE_BLACK, PIECE_ROOK);
      run_eval("no kings", 1'b0);

      // Random codes, unused kind 7 included
      for (int t = 0; t < NUM_RANDOM; t++)
      begin
         density = int'($urandom_range(90, 5));
         for (int i = 0; i < 64; i++)
         begin
            if (int'($urandom_range(99, 0)) < density)
               tb_board[sq_idx_t'(i)] = piece_t'(4'($urandom_range(15, 0)));
            else
               tb_board[sq_idx_t'(i)] = '0;
         end
         run_eval($sformatf("random board %0d density %0d", t, density), 1'b0);
      end

      // Start repeated one cycle later is dropped
      run_eval("start while busy", 1'b1);

      $display("Summary: %0d tests, %0d passed, %0d failed, %0d value mismatches",
               test_idx, tests_passed, tests_failed, mismatch_count);
      if (tests_failed == 0 && mismatch_count == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
      $display("Some tests failed");
      $finish;
   end

endmodule

/* files.f */
source/chess_pkg.sv
source/board_store.sv
source/square_attack.sv
source/board_attack.sv
source/king_check.sv
source/chess_attack_top.sv
tb/chess_attack_sva.sv
tb/tb_chess_attack.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the chess attack testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_chess_attack -f files.f \
   || { echo "Verilator build failed"; exit 1; }
./obj_dir/Vtb_chess_attack > sim.log 2>&1
run_status=$?
cat sim.log
grep -q "Some tests failed" sim.log && { echo "Simulation FAILED"; exit 1; }
[ "$run_status" -eq 0 ] && grep -q "All tests passed" sim.log \
   || { echo "Simulation FAILED"; exit 1; }
echo "Simulation PASSED"
